// File: src.f
src/core_pkg.sv
src/register_file.sv
src/instr_decoder.sv
src/alu.sv
src/exec_core.sv
tb/exec_core_properties.sv
tb/exec_core_tb.sv

// File: Makefile
# Verilator build and run of the execution core testbench

VERILATOR ?= verilator
TOP       ?= exec_core_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?=

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables (override on the command line):"
	@echo "  VERILATOR=$(VERILATOR) TOP=$(TOP) FILELIST=$(FILELIST)"
	@echo "  BUILD_DIR=$(BUILD_DIR) VFLAGS='$(VFLAGS)' SIM_ARGS='$(SIM_ARGS)'"

# The simulator exit status carries pass or fail
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -o $(TOP) -f $(FILELIST)
	./$(BUILD_DIR)/$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)

// File: tb/exec_core_tb.sv
// Testbench for the execution core with clock, reset, random stimulus, reference model and checks
`timescale 1ns/100ps

module exec_core_tb import core_pkg::*; ();

    localparam int reset_cycles  = 8;
    localparam int init_cycles   = 62;
    localparam int rand_cycles   = 2000;
    localparam int sweep_cycles  = 31;
    localparam int run_cycles    = init_cycles + rand_cycles + sweep_cycles + 4;
    // Twice the planned stimulus plus the reset time
    localparam int timeout_limit = 2 * run_cycles + reset_cycles;

    logic    clk;
    logic    rst_n;
    logic    instr_valid;
    instr_u  instr;
    logic    result_valid;
    result_t result;

    // Reference register file where entry 0 is never written
    logic [31:0] model_regs [0:31];
    logic        exp_valid;
    result_t     exp_result;
    logic [4:0]  last_rd;
    int          cycles = 0;

    exec_core i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .result_valid (result_valid),
        .result       (result)
    );

    always #20 clk = ~clk;

    // Ends a run that never reaches the end of its stimulus
    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles > timeout_limit)
        begin
            $display("Timeout after %0d cycles without reaching the end of the test", cycles);
            report_failure();
        end
    end

    task automatic report_failure();
        $display("Done: errors found");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_field(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else
        begin
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
            report_failure();
        end
    endtask

    // Executes one word against the model registers as they stand before the edge
    function automatic result_t model_exec(input logic [31:0] w);
        logic [5:0]  opcode;
        logic [15:0] imm;
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sh;
        logic        lt;
        result_t     r;
        opcode    = w[31:26];
        imm       = w[15:0];
        a         = model_regs[w[20:16]];
        b         = model_regs[w[15:11]];
        sh        = b[4:0];
        r.rd      = w[25:21];
        r.illegal = 1'b0;
        // Illegal words report the rt register unchanged
        r.value   = b;
        case (opcode)
            6'd0:
            begin
                case (w[3:0])
                    4'd0: r.value = a + b;
                    4'd1: r.value = a - b;
                    4'd2: r.value = a & b;
                    4'd3: r.value = a | b;
                    4'd4: r.value = a ^ b;
                    4'd5: r.value = a << sh;
                    4'd6: r.value = a >> sh;
                    4'd7: r.value = a[31] ? ((a >> sh) | ~(32'hffff_ffff >> sh)) : (a >> sh);
                    4'd8:
                    begin
                        // Differing signs decide a signed compare by the sign of a
                        lt      = (a[31] != b[31]) ? a[31] : (a < b);
                        r.value = {31'b0, lt};
                    end
                    4'd9: r.value = {31'b0, a < b};
                    default: r.illegal = 1'b1;
                endcase
            end
            6'd1: r.value = a + {{16{imm[15]}}, imm};
            6'd2: r.value = a & {16'h0000, imm};
            6'd3: r.value = a | {16'h0000, imm};
            6'd4: r.value = {imm, 16'h0000};
            default: r.illegal = 1'b1;
        endcase
        return r;
    endfunction

    // Mix of about 60 % register format, 30 % immediate format and 10 % illegal words
    function automatic logic [31:0] random_instr();
        int          pick;
        logic [4:0]  rd;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
        logic [31:0] w;
        pick = int'($urandom_range(99));
        rd   = 5'($urandom_range(31));
        rs   = 5'($urandom_range(31));
        rt   = 5'($urandom_range(31));
        imm  = 16'($urandom);
        // Often read the register written just before
        if ($urandom_range(3) == 0)
        begin
            rs = last_rd;
        end
        if (pick < 60)
            w = {6'd0, rd, rs, rt, 7'($urandom), 4'($urandom_range(9))};
        else if (pick < 90)
            w = {6'($urandom_range(4, 1)), rd, rs, imm};
        else if ($urandom_range(1) == 1)
            w = {6'd0, rd, rs, rt, 7'($urandom), 4'($urandom_range(15, 10))};
        else
            w = {6'($urandom_range(63, 5)), rd, rs, imm};
        return w;
    endfunction

    // Outputs were updated at the last rising edge and are stable here
    task automatic check_outputs();
        check_field("result_valid", 32'(exp_valid), 32'(result_valid));
        if (exp_valid)
        begin
            check_field("result.rd", 32'(exp_result.rd), 32'(result.rd));
            check_field("result.value", exp_result.value, result.value);
            check_field("result.illegal", 32'(exp_result.illegal), 32'(result.illegal));
        end
    endtask

    // Called at a falling edge to check the previous result, drive the inputs and update the model
    task automatic apply_cycle(input logic v, input logic [31:0] w);
        check_outputs();
        instr_valid = v;
        instr       = w;
        exp_valid   = v;
        if (v)
        begin
            exp_result = model_exec(w);
            if (!exp_result.illegal && exp_result.rd != 5'd0)
            begin
                model_regs[exp_result.rd] = exp_result.value;
            end
            last_rd = exp_result.rd;
        end
        @(negedge clk);
    endtask

    initial
    begin
        logic [31:0] val;
        void'($urandom(66131));
        clk         = 1'b0;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        exp_valid   = 1'b0;
        exp_result  = '0;
        last_rd     = 5'd0;
        for (int i = 0; i < 32; i++)
        begin
            model_regs[i] = 32'h0;
        end
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // The result register comes out of reset cleared
        check_field("result.rd", 32'h0, 32'(result.rd));
        check_field("result.value", 32'h0, result.value);
        check_field("result.illegal", 32'h0, 32'(result.illegal));
        // Quiet cycles show that no result appears without a strobe
        apply_cycle(1'b0, 32'h0);
        apply_cycle(1'b0, 32'h0);
        // Load every register with a known value through lui and ori
        for (int r = 1; r < 32; r++)
        begin
            val = $urandom;
            apply_cycle(1'b1, {6'd4, 5'(r), 5'd0, val[31:16]});
            apply_cycle(1'b1, {6'd3, 5'(r), 5'(r), val[15:0]});
        end
        repeat (rand_cycles)
        begin
            apply_cycle($urandom_range(99) < 70, random_instr());
        end
        // Read back every register as an or with r0 whose result is discarded into r0
        for (int r = 1; r < 32; r++)
        begin
            apply_cycle(1'b1, {6'd0, 5'd0, 5'(r), 5'd0, 7'd0, 4'd3});
        end
        apply_cycle(1'b0, 32'h0);
        check_outputs();
        $display("Done: no errors");
        $finish;
    end

endmodule

// File: tb/exec_core_properties.sv
// Concurrent assertions on result strobe timing, zero register reads and reset, bound to exec_core
`timescale 1ns/100ps

module exec_core_properties import core_pkg::*; (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  instr_valid,
    input logic                  result_valid,
    input logic [reg_addr_w-1:0] raddr_a,
    input logic [reg_addr_w-1:0] raddr_b,
    input logic [xlen-1:0]       rdata_a,
    input logic [xlen-1:0]       rdata_b
);

    // Exactly one result strobe for each instruction strobe, one cycle later
    a_result_follows_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid == $past(instr_valid))
        else $error("result_valid is not instr_valid delayed by one cycle");

    // Register 0 reads as zero on both ports
    a_zero_port_a: assert property (@(posedge clk) (raddr_a == '0) |-> (rdata_a == '0))
        else $error("read port a returned nonzero data for register 0");

    a_zero_port_b: assert property (@(posedge clk) (raddr_b == '0) |-> (rdata_b == '0))
        else $error("read port b returned nonzero data for register 0");

    a_quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !result_valid)
        else $error("result_valid was high during reset");

endmodule

bind exec_core exec_core_properties i_properties (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr_valid  (instr_valid),
    .result_valid (result_valid),
    .raddr_a      (decoded.rs),
    .raddr_b      (decoded.rt),
    .rdata_a      (rdata_a),
    .rdata_b      (rdata_b)
);

// File: src/exec_core.sv
// Execution core top level with decoder, register file, ALU and the registered result
`timescale 1ns/100ps

module exec_core import core_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    instr_valid,
    input  instr_u  instr,
    output logic    result_valid,
    output result_t result
);

    decoded_t        decoded;
    logic [xlen-1:0] rdata_a;
    logic [xlen-1:0] rdata_b;
    logic [xlen-1:0] operand_b;
    logic [xlen-1:0] alu_y;
    logic            wr_en;

    instr_decoder i_decoder (
        .instr   (instr),
        .decoded (decoded)
    );

    // The write lands on the same edge that accepts the instruction,
    // so the next instruction reads it without any forwarding
    register_file i_register_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .raddr_a (decoded.rs),
        .raddr_b (decoded.rt),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b),
        .we      (wr_en),
        .waddr   (decoded.rd),
        .wdata   (alu_y)
    );

    // Second operand is the extended immediate or the rt register
    assign operand_b = decoded.use_imm ? decoded.imm_ext : rdata_b;

    alu i_alu (
        .op (decoded.alu_op),
        .a  (rdata_a),
        .b  (operand_b),
        .y  (alu_y)
    );

    // Illegal words must leave the register file untouched
    assign wr_en = instr_valid && !decoded.illegal;

    // Result strobe follows each accepted instruction by exactly one cycle
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            result_valid <= 1'b0;
            result       <= '0;
        end
        else
        begin
            result_valid <= instr_valid;
            // Hold the last result between strobes
            if (instr_valid)
            begin
                result.rd      <= decoded.rd;
                result.value   <= alu_y;
                result.illegal <= decoded.illegal;
            end
        end
    end

endmodule

// File: src/alu.sv
// Combinational ALU with arithmetic, logic, shift, compare and pass-through operations
`timescale 1ns/100ps

module alu import core_pkg::*; (
    input  alu_op_e         op,
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    output logic [xlen-1:0] y
);

    // Shift distance uses only as many low bits of b as a word needs
    localparam int unsigned shamt_w = $clog2(xlen);

    logic [shamt_w-1:0] shamt;

    assign shamt = b[shamt_w-1:0];

    always_comb
    begin
        case (op)
            alu_add:
            begin
                y = a + b;
            end
            alu_sub:
            begin
                y = a - b;
            end
            alu_and:
            begin
                y = a & b;
            end
            alu_or:
            begin
                y = a | b;
            end
            alu_xor:
            begin
                y = a ^ b;
            end
            alu_sll:
            begin
                y = a << shamt;
            end
            alu_srl:
            begin
                y = a >> shamt;
            end
            alu_sra:
            begin
                // Arithmetic shift copies the sign bit into the vacated bits
                y = $signed(a) >>> shamt;
            end
            alu_slt:
            begin
                // Compare results are zero-extended single bits
                y = xlen'($signed(a) < $signed(b));
            end
            alu_sltu:
            begin
                y = xlen'(a < b);
            end
            default:
            begin
                // Covers alu_pass_b and the unused enum codes
                y = b;
            end
        endcase
    end

endmodule

// File: src/instr_decoder.sv
// Instruction decoder for the register and immediate formats
`timescale 1ns/100ps

module instr_decoder import core_pkg::*; (
    input  instr_u   instr,
    output decoded_t decoded
);

    // Highest funct value that names an ALU operation
    localparam logic [3:0] funct_last = 4'(alu_sltu);

    // Immediate field taken through the i_fmt view
    logic [15:0] imm;

    assign imm = instr.i_fmt.imm;

    always_comb
    begin
        // Register fields sit at the same bits in both formats,
        // so they are always taken from the r_fmt view
        decoded.rs      = instr.r_fmt.rs;
        decoded.rt      = instr.r_fmt.rt;
        decoded.rd      = instr.r_fmt.rd;

        // Defaults describe an illegal word that passes rt through
        decoded.alu_op  = alu_pass_b;
        decoded.use_imm = 1'b0;
        decoded.imm_ext = '0;
        decoded.illegal = 1'b0;

        case (instr.r_fmt.opcode)
            op_reg:
            begin
                // funct 0 to 9 maps straight onto the enum order
                if (instr.r_fmt.funct > funct_last)
                begin
                    decoded.illegal = 1'b1;
                end
                else
                begin
                    decoded.alu_op = alu_op_e'(instr.r_fmt.funct);
                end
            end
            op_addi:
            begin
                decoded.alu_op  = alu_add;
                decoded.use_imm = 1'b1;
                decoded.imm_ext = {{16{imm[15]}}, imm};
            end
            op_andi:
            begin
                decoded.alu_op  = alu_and;
                decoded.use_imm = 1'b1;
                decoded.imm_ext = {16'h0000, imm};
            end
            op_ori:
            begin
                decoded.alu_op  = alu_or;
                decoded.use_imm = 1'b1;
                decoded.imm_ext = {16'h0000, imm};
            end
            op_lui:
            begin
                // Upper half load, the ALU simply passes the shifted immediate
                decoded.alu_op  = alu_pass_b;
                decoded.use_imm = 1'b1;
                decoded.imm_ext = {imm, 16'h0000};
            end
            default:
            begin
                decoded.illegal = 1'b1;
            end
        endcase
    end

endmodule

// File: src/register_file.sv
// Register file with 31 storage words, two combinational read ports and one write port
`timescale 1ns/100ps

module register_file import core_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [reg_addr_w-1:0] raddr_a,
    input  logic [reg_addr_w-1:0] raddr_b,
    output logic [xlen-1:0]       rdata_a,
    output logic [xlen-1:0]       rdata_b,
    input  logic                  we,
    input  logic [reg_addr_w-1:0] waddr,
    input  logic [xlen-1:0]       wdata
);

    // Number of architectural registers addressed by reg_addr_w bits
    localparam int unsigned nregs = 1 << reg_addr_w;

    // Storage exists only for registers 1 and up
    logic [xlen-1:0] regs [1:nregs-1];

    // One-hot write select, one bit per stored register
    logic [nregs-1:1] wr_sel;

    // Each stored register decodes its own address and owns its own flop bank
    for (genvar i = 1; i < nregs; i++)
    begin : g_reg
        // A write to address 0 matches no bit here and is dropped
        assign wr_sel[i] = we && (waddr == reg_addr_w'(i));

        always_ff @(posedge clk or negedge rst_n)
        begin
            if (!rst_n)
            begin
                regs[i] <= '0;
            end
            else if (wr_sel[i])
            begin
                regs[i] <= wdata;
            end
        end
    end

    // Read ports are pure muxes, so a word written at an edge is
    // visible on them right after that edge
    // Address 0 has no storage and is forced to zero on both ports
    always_comb
    begin
        rdata_a = '0;
        if (raddr_a != '0)
        begin
            rdata_a = regs[raddr_a];
        end
    end

    always_comb
    begin
        rdata_b = '0;
        if (raddr_b != '0)
        begin
            rdata_b = regs[raddr_b];
        end
    end

endmodule

// File: src/core_pkg.sv
// Shared word constants, instruction formats, ALU operation codes and core result types
package core_pkg;

    // Data word width of the register file and the ALU
    localparam int unsigned xlen = 32;

    // Register address width, which fixes the file at 32 entries
    localparam int unsigned reg_addr_w = 5;

    // Major opcodes in the top six bits of the instruction word
    localparam logic [5:0] op_reg  = 6'd0;
    localparam logic [5:0] op_addi = 6'd1;
    localparam logic [5:0] op_andi = 6'd2;
    localparam logic [5:0] op_ori  = 6'd3;
    localparam logic [5:0] op_lui  = 6'd4;

    // Register-register format, where funct selects the operation
    typedef struct packed {
        logic [5:0]            opcode;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rs;
        logic [reg_addr_w-1:0] rt;
        logic [6:0]            unused;
        logic [3:0]            funct;
    } r_fmt_t;

    // Register-immediate format; opcode, rd and rs sit where the r_fmt ones do
    typedef struct packed {
        logic [5:0]            opcode;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rs;
        logic [15:0]           imm;
    } i_fmt_t;

    // One 32-bit instruction word seen through either format
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_u;

    // The first ten codes follow funct 0 to 9 in order, pass_b is internal only
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt,
        alu_sltu,
        alu_pass_b
    } alu_op_e;

    // Everything the datapath needs from one decoded instruction
    typedef struct packed {
        logic [reg_addr_w-1:0] rs;
        logic [reg_addr_w-1:0] rt;
        logic [reg_addr_w-1:0] rd;
        alu_op_e               alu_op;
        logic                  use_imm;
        logic [xlen-1:0]       imm_ext;
        logic                  illegal;
    } decoded_t;

    // Value reported one cycle after the instruction strobe
    typedef struct packed {
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       value;
        logic                  illegal;
    } result_t;

endpackage
